//--- verilog/core_pkg.sv
package core_pkg;

  // data and address width
  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;      // data or address word
  typedef logic [4:0]      reg_idx_t;   // x0 .. x31
  typedef logic [3:0]      byte_mask_t; // one bit per byte lane

  // first adder operand
  typedef enum logic [1:0] {
    op_a_rs1  = 2'd0,
    op_a_pc   = 2'd1,
    op_a_zero = 2'd2  // lui, imm passes straight through
  } op_a_sel_t;

  // source of the register write-back value
  typedef enum logic [1:0] {
    wb_sum      = 2'd0, // adder result
    wb_pc_plus4 = 2'd1, // link address for jal/jalr
    wb_load     = 2'd2  // extended load data
  } wb_sel_t;

endpackage

//--- verilog/rv_isa_pkg.sv
package rv_isa_pkg;

  // field widths
  localparam int opcode_w    = 7;
  localparam int funct3_w    = 3;
  localparam int reg_field_w = 5;

  // field positions, lsb of each field
  localparam int rd_lsb     = 7;
  localparam int funct3_lsb = 12;
  localparam int rs1_lsb    = 15;
  localparam int rs2_lsb    = 20;

  // opcodes
  localparam logic [opcode_w-1:0] opc_op_imm = 7'b001_0011;
  localparam logic [opcode_w-1:0] opc_auipc  = 7'b001_0111;
  localparam logic [opcode_w-1:0] opc_lui    = 7'b011_0111;
  localparam logic [opcode_w-1:0] opc_jal    = 7'b110_1111;
  localparam logic [opcode_w-1:0] opc_jalr   = 7'b110_0111;
  localparam logic [opcode_w-1:0] opc_load   = 7'b000_0011;
  localparam logic [opcode_w-1:0] opc_store  = 7'b010_0011;
  localparam logic [opcode_w-1:0] opc_system = 7'b111_0011;

  // load/store width encodings
  localparam logic [funct3_w-1:0] f3_byte   = 3'b000;
  localparam logic [funct3_w-1:0] f3_half   = 3'b001;
  localparam logic [funct3_w-1:0] f3_word   = 3'b010;
  localparam logic [funct3_w-1:0] f3_byte_u = 3'b100;
  localparam logic [funct3_w-1:0] f3_half_u = 3'b101;

endpackage

//--- verilog/pc_unit.sv
`timescale 1ns/1ps

module pc_unit #(
  parameter core_pkg::word_t reset_pc = 32'h8000_0000
) (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            jump,
  input  logic            jalr,
  input  core_pkg::word_t target,
  output core_pkg::word_t pc,
  output core_pkg::word_t pc_plus4
);

  core_pkg::word_t next_pc;

  assign pc_plus4 = pc + 32'd4;

  always_comb begin
    next_pc = pc_plus4;
    if (jump) begin
      // jalr drops bit 0 of rs1 + imm
      next_pc = jalr ? {target[31:1], 1'b0} : target;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= reset_pc;
    end else begin
      pc <= next_pc;
    end
  end

  // no compressed support, so every target must land on a word
  assert property (@(posedge clk) disable iff (!arst_n) pc[1:0] == 2'b00)
    else $error("pc not word aligned: %h", pc);

endmodule

//--- verilog/decoder.sv
`timescale 1ns/1ps

module decoder (
  input  core_pkg::word_t                   inst,
  output core_pkg::reg_idx_t                rs1,
  output core_pkg::reg_idx_t                rs2,
  output core_pkg::reg_idx_t                rd,
  output core_pkg::word_t                   imm,
  output core_pkg::op_a_sel_t               op_a_sel,
  output core_pkg::wb_sel_t                 wb_sel,
  output logic                              reg_we,
  output logic                              mem_re,
  output logic                              mem_we,
  output logic                              jump,
  output logic                              jalr,
  output logic                              halt,
  output logic [rv_isa_pkg::funct3_w-1:0]   funct3
);

  logic [rv_isa_pkg::opcode_w-1:0] opcode;
  core_pkg::word_t imm_i;
  core_pkg::word_t imm_s;
  core_pkg::word_t imm_u;
  core_pkg::word_t imm_j;

  // field split
  assign opcode = inst[rv_isa_pkg::opcode_w-1:0];
  assign rd     = inst[rv_isa_pkg::rd_lsb +: rv_isa_pkg::reg_field_w];
  assign rs1    = inst[rv_isa_pkg::rs1_lsb +: rv_isa_pkg::reg_field_w];
  assign rs2    = inst[rv_isa_pkg::rs2_lsb +: rv_isa_pkg::reg_field_w];
  assign funct3 = inst[rv_isa_pkg::funct3_lsb +: rv_isa_pkg::funct3_w];

  // immediates, all sign extended from bit 31
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_u = {inst[31:12], 12'h000};
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    // unknown opcodes fall through as a nop
    imm      = imm_i;
    op_a_sel = core_pkg::op_a_rs1;
    wb_sel   = core_pkg::wb_sum;
    reg_we   = 1'b0;
    mem_re   = 1'b0;
    mem_we   = 1'b0;
    jump     = 1'b0;
    jalr     = 1'b0;
    halt     = 1'b0;
    case (opcode)
      rv_isa_pkg::opc_op_imm: begin
        reg_we = 1'b1; // always an add, funct3 not looked at
      end
      rv_isa_pkg::opc_lui: begin
        imm      = imm_u;
        op_a_sel = core_pkg::op_a_zero;
        reg_we   = 1'b1;
      end
      rv_isa_pkg::opc_auipc: begin
        imm      = imm_u;
        op_a_sel = core_pkg::op_a_pc;
        reg_we   = 1'b1;
      end
      rv_isa_pkg::opc_jal: begin
        imm      = imm_j;
        op_a_sel = core_pkg::op_a_pc;
        wb_sel   = core_pkg::wb_pc_plus4;
        reg_we   = 1'b1;
        jump     = 1'b1;
      end
      rv_isa_pkg::opc_jalr: begin
        wb_sel = core_pkg::wb_pc_plus4;
        reg_we = 1'b1;
        jump   = 1'b1;
        jalr   = 1'b1;
      end
      rv_isa_pkg::opc_load: begin
        wb_sel = core_pkg::wb_load;
        reg_we = 1'b1;
        mem_re = 1'b1;
      end
      rv_isa_pkg::opc_store: begin
        imm    = imm_s;
        mem_we = 1'b1;
      end
      rv_isa_pkg::opc_system: begin
        // ebreak only, ecall and csr ops stay nops
        halt = (funct3 == 3'b000) && (inst[31:20] == 12'h001);
      end
      default: ;
    endcase
  end

endmodule

//--- verilog/register_file.sv
`timescale 1ns/1ps

module register_file (
  input  logic               clk,
  input  logic               arst_n,
  input  core_pkg::reg_idx_t rs1,
  input  core_pkg::reg_idx_t rs2,
  input  core_pkg::reg_idx_t rd,
  input  logic               we,
  input  core_pkg::word_t    wdata,
  output core_pkg::word_t    rs1_data,
  output core_pkg::word_t    rs2_data
);

  core_pkg::word_t regs [32];

  // x0 is hardwired, entry 0 is never written
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      regs <= '{default: '0};
    end else if (we && (rd != 5'd0)) begin
      regs[rd] <= wdata;
    end
  end

  // combinational reads, a write shows up next cycle
  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

//--- verilog/exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
  input  core_pkg::word_t     pc,
  input  core_pkg::word_t     pc_plus4,
  input  core_pkg::word_t     rs1_data,
  input  core_pkg::word_t     imm,
  input  core_pkg::word_t     load_data,
  input  core_pkg::op_a_sel_t op_a_sel,
  input  core_pkg::wb_sel_t   wb_sel,
  output core_pkg::word_t     sum,
  output core_pkg::word_t     rd_data
);

  core_pkg::word_t op_a;

  always_comb begin
    case (op_a_sel)
      core_pkg::op_a_pc:   op_a = pc;   // auipc, jal
      core_pkg::op_a_zero: op_a = '0;   // lui
      default:             op_a = rs1_data;
    endcase
  end

  // single adder, serves add results, addresses and jump targets
  assign sum = op_a + imm;

  always_comb begin
    case (wb_sel)
      core_pkg::wb_pc_plus4: rd_data = pc_plus4;
      core_pkg::wb_load:     rd_data = load_data;
      default:               rd_data = sum;
    endcase
  end

endmodule

//--- verilog/lsu.sv
`timescale 1ns/1ps

module lsu (
  input  core_pkg::word_t                 addr,
  input  core_pkg::word_t                 rs2_data,
  input  core_pkg::word_t                 mem_rdata,
  input  logic [rv_isa_pkg::funct3_w-1:0] funct3,
  input  logic                            mem_re,
  input  logic                            mem_we,
  output core_pkg::word_t                 mem_addr,
  output core_pkg::word_t                 mem_wdata,
  output core_pkg::byte_mask_t            mem_wmask,
  output logic                            mem_re_out,
  output logic                            mem_we_out,
  output core_pkg::word_t                 load_data
);

  logic [1:0]      offset;
  logic [4:0]      shamt;     // byte offset in bits
  core_pkg::word_t rdata_sh;  // addressed lane moved to bit 0
  logic            misaligned;

  assign offset     = addr[1:0];
  assign shamt      = {offset, 3'b000};
  assign mem_addr   = {addr[31:2], 2'b00};
  assign mem_re_out = mem_re;
  assign mem_we_out = mem_we;

  // store side, data lands on the lanes the mask enables
  always_comb begin
    mem_wmask = 4'b0000;
    mem_wdata = '0;
    if (mem_we) begin
      case (funct3)
        rv_isa_pkg::f3_byte: begin
          mem_wmask = 4'b0001 << offset;
          mem_wdata = {24'h00_0000, rs2_data[7:0]} << shamt;
        end
        rv_isa_pkg::f3_half: begin
          mem_wmask = offset[1] ? 4'b1100 : 4'b0011;
          mem_wdata = {16'h0000, rs2_data[15:0]} << shamt;
        end
        rv_isa_pkg::f3_word: begin
          mem_wmask = 4'b1111;
          mem_wdata = rs2_data;
        end
        default: ; // no write
      endcase
    end
  end

  // load side
  assign rdata_sh = mem_rdata >> shamt;

  always_comb begin
    case (funct3)
      rv_isa_pkg::f3_byte:   load_data = {{24{rdata_sh[7]}}, rdata_sh[7:0]};
      rv_isa_pkg::f3_byte_u: load_data = {24'h00_0000, rdata_sh[7:0]};
      rv_isa_pkg::f3_half:   load_data = {{16{rdata_sh[15]}}, rdata_sh[15:0]};
      rv_isa_pkg::f3_half_u: load_data = {16'h0000, rdata_sh[15:0]};
      rv_isa_pkg::f3_word:   load_data = mem_rdata;
      default:               load_data = '0;
    endcase
  end

  always_comb begin
    misaligned = 1'b0;
    if (funct3 == rv_isa_pkg::f3_half || funct3 == rv_isa_pkg::f3_half_u) begin
      misaligned = offset[0];
    end else if (funct3 == rv_isa_pkg::f3_word) begin
      misaligned = (offset != 2'b00);
    end
    // no split accesses, the memory sees one aligned word
    assert final (!((mem_re || mem_we) && misaligned))
      else $error("misaligned access at %h, funct3 %b", addr, funct3);
  end

endmodule

//--- verilog/rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top #(
  parameter core_pkg::word_t reset_pc = 32'h8000_0000
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  core_pkg::word_t      inst,
  input  core_pkg::word_t      mem_rdata,
  output core_pkg::word_t      pc,
  output core_pkg::word_t      mem_addr,
  output core_pkg::word_t      mem_wdata,
  output core_pkg::byte_mask_t mem_wmask,
  output logic                 mem_we,
  output logic                 mem_re,
  output logic                 halt
);

  core_pkg::reg_idx_t  rs1;
  core_pkg::reg_idx_t  rs2;
  core_pkg::reg_idx_t  rd;
  core_pkg::word_t     imm;
  core_pkg::op_a_sel_t op_a_sel;
  core_pkg::wb_sel_t   wb_sel;
  logic                reg_we;
  logic                dec_mem_re; // before the lsu
  logic                dec_mem_we;
  logic                jump;
  logic                jalr;
  logic [2:0]          funct3;

  core_pkg::word_t     pc_plus4;
  core_pkg::word_t     rs1_data;
  core_pkg::word_t     rs2_data;
  core_pkg::word_t     sum;       // jump target and memory address
  core_pkg::word_t     rd_data;
  core_pkg::word_t     load_data;

  pc_unit #(.reset_pc(reset_pc)) i_pc_unit (
    .clk      (clk),
    .arst_n   (arst_n),
    .jump     (jump),
    .jalr     (jalr),
    .target   (sum),
    .pc       (pc),
    .pc_plus4 (pc_plus4)
  );

  decoder i_decoder (
    .inst     (inst),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (rd),
    .imm      (imm),
    .op_a_sel (op_a_sel),
    .wb_sel   (wb_sel),
    .reg_we   (reg_we),
    .mem_re   (dec_mem_re),
    .mem_we   (dec_mem_we),
    .jump     (jump),
    .jalr     (jalr),
    .halt     (halt),
    .funct3   (funct3)
  );

  register_file i_register_file (
    .clk      (clk),
    .arst_n   (arst_n),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (rd),
    .we       (reg_we),
    .wdata    (rd_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  exec_unit i_exec_unit (
    .pc        (pc),
    .pc_plus4  (pc_plus4),
    .rs1_data  (rs1_data),
    .imm       (imm),
    .load_data (load_data),
    .op_a_sel  (op_a_sel),
    .wb_sel    (wb_sel),
    .sum       (sum),
    .rd_data   (rd_data)
  );

  lsu i_lsu (
    .addr       (sum),
    .rs2_data   (rs2_data),
    .mem_rdata  (mem_rdata),
    .funct3     (funct3),
    .mem_re     (dec_mem_re),
    .mem_we     (dec_mem_we),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_wmask  (mem_wmask),
    .mem_re_out (mem_re),
    .mem_we_out (mem_we),
    .load_data  (load_data)
  );

endmodule

//--- testbench/tb_program.svh
// each row: name, inst, mem_rdata, we, re, mem_addr, wmask, wdata, halt
task automatic build_program();
  logic [2:0]      ld_f3 [5];
  string           ld_nm [5];
  core_pkg::word_t rd_word;
  core_pkg::word_t ext;
  int              offs;
  add_row("lui_base", enc_u(20'h00001, 5'd2, rv_isa_pkg::opc_lui), '0, 0, 0, '0, 4'h0, '0, 0);
  add_row("addi_x1", enc_i(12'h123, 5'd0, 3'b000, 5'd1, rv_isa_pkg::opc_op_imm), '0, 0, 0, '0,
          4'h0, '0, 0);
  add_row("sw_addi", enc_s(12'd0, 5'd1, 5'd2, 3'b010), '0, 1, 0, 32'h1000, 4'hf, 32'h123, 0);
  add_row("addi_neg", enc_i(12'hfff, 5'd1, 3'b000, 5'd3, rv_isa_pkg::opc_op_imm), '0, 0, 0, '0,
          4'h0, '0, 0);
  add_row("sw_neg", enc_s(12'd4, 5'd3, 5'd2, 3'b010), '0, 1, 0, 32'h1004, 4'hf, 32'h122, 0);
  add_row("addi_x0", enc_i(12'h007, 5'd1, 3'b000, 5'd0, rv_isa_pkg::opc_op_imm), '0, 0, 0, '0,
          4'h0, '0, 0);
  add_row("sw_x0", enc_s(12'd8, 5'd0, 5'd2, 3'b010), '0, 1, 0, 32'h1008, 4'hf, 32'h0, 0);
  add_row("auipc", enc_u(20'h12345, 5'd4, rv_isa_pkg::opc_auipc), '0, 0, 0, '0, 4'h0, '0, 0);
  add_row("sw_auipc", enc_s(12'd12, 5'd4, 5'd2, 3'b010), '0, 1, 0, 32'h100c, 4'hf,
          32'h9234_501c, 0);
  add_row("sw_lui", enc_s(12'd16, 5'd2, 5'd2, 3'b010), '0, 1, 0, 32'h1010, 4'hf, 32'h1000, 0);
  add_row("jal", enc_j(21'd16, 5'd5), '0, 0, 0, '0, 4'h0, '0, 0);
  exp_pc = 32'h8000_0038; // jal lands 16 bytes ahead
  add_row("sw_jal_link", enc_s(12'd20, 5'd5, 5'd2, 3'b010), '0, 1, 0, 32'h1014, 4'hf,
          32'h8000_002c, 0);
  add_row("lui_hi", enc_u(20'h80000, 5'd6, rv_isa_pkg::opc_lui), '0, 0, 0, '0, 4'h0, '0, 0);
  add_row("addi_odd", enc_i(12'h059, 5'd6, 3'b000, 5'd6, rv_isa_pkg::opc_op_imm), '0, 0, 0, '0,
          4'h0, '0, 0);
  add_row("jalr", enc_i(12'd0, 5'd6, 3'b000, 5'd7, rv_isa_pkg::opc_jalr), '0, 0, 0, '0, 4'h0,
          '0, 0);
  exp_pc = 32'h8000_0058; // bit 0 of 0x80000059 dropped
  add_row("sw_jalr_link", enc_s(12'd24, 5'd7, 5'd2, 3'b010), '0, 1, 0, 32'h1018, 4'hf,
          32'h8000_0048, 0);
  add_row("lui_data", enc_u(20'hcafeb, 5'd8, rv_isa_pkg::opc_lui), '0, 0, 0, '0, 4'h0, '0, 0);
  add_row("addi_data", enc_i(12'h7a5, 5'd8, 3'b000, 5'd8, rv_isa_pkg::opc_op_imm), '0, 0, 0,
          '0, 4'h0, '0, 0);
  for (int k = 0; k < 4; k++) begin
    add_row($sformatf("sb_off%0d", k), enc_s(12'(k), 5'd8, 5'd2, rv_isa_pkg::f3_byte), '0, 1, 0,
            32'h1000, 4'(1 << k), 32'h0000_00a5 << (8 * k), 0);
  end
  add_row("sh_off0", enc_s(12'd0, 5'd8, 5'd2, rv_isa_pkg::f3_half), '0, 1, 0, 32'h1000, 4'h3,
          32'h0000_b7a5, 0);
  add_row("sh_off2", enc_s(12'd2, 5'd8, 5'd2, rv_isa_pkg::f3_half), '0, 1, 0, 32'h1000, 4'hc,
          32'hb7a5_0000, 0);
  ld_f3 = '{rv_isa_pkg::f3_byte, rv_isa_pkg::f3_byte_u, rv_isa_pkg::f3_half,
            rv_isa_pkg::f3_half_u, rv_isa_pkg::f3_word};
  ld_nm = '{"lb", "lbu", "lh", "lhu", "lw"};
  for (int t = 0; t < 5; t++) begin
    offs = (t < 2) ? 4 : ((t < 4) ? 2 : 1); // legal offsets per width
    for (int k = 0; k < offs; k++) begin
      rd_word = $urandom; // unselected lanes stay random
      if (t < 2) begin
        rd_word[8*k +: 8] = 8'h9c;
        ext = (t == 0) ? 32'hffff_ff9c : 32'h0000_009c;
      end else if (t < 4) begin
        rd_word[16*k +: 16] = 16'h8d31;
        ext = (t == 2) ? 32'hffff_8d31 : 32'h0000_8d31;
      end else begin
        ext = rd_word;
      end
      add_row($sformatf("%s_off%0d", ld_nm[t], k * ((t < 2) ? 1 : 2)),
              enc_i(12'(k * ((t < 2) ? 1 : 2)), 5'd2, ld_f3[t], 5'd9, rv_isa_pkg::opc_load),
              rd_word, 0, 1, 32'h1000, 4'h0, '0, 0);
      add_row($sformatf("sw_%s_%0d", ld_nm[t], k), enc_s(12'd0, 5'd9, 5'd2, 3'b010), '0, 1, 0,
              32'h1000, 4'hf, ext, 0);
    end
  end
  add_row("ebreak", 32'h0010_0073, '0, 0, 0, '0, 4'h0, '0, 1);
endtask

//--- testbench/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

  localparam time clk_period = 100ns;
  localparam int  halt_timeout = 20; // cycles

  logic                 clk;
  logic                 arst_n;
  core_pkg::word_t      inst;
  core_pkg::word_t      mem_rdata;
  core_pkg::word_t      pc;
  core_pkg::word_t      mem_addr;
  core_pkg::word_t      mem_wdata;
  core_pkg::byte_mask_t mem_wmask;
  logic                 mem_we;
  logic                 mem_re;
  logic                 halt;

  // stimulus and expected values, one entry per cycle
  string                names [$];
  core_pkg::word_t      insts [$];
  core_pkg::word_t      rdatas [$];
  core_pkg::word_t      exp_pcs [$];
  logic                 exp_wes [$];
  logic                 exp_res [$];
  core_pkg::word_t      exp_addrs [$];
  core_pkg::byte_mask_t exp_masks [$];
  core_pkg::word_t      exp_wdatas [$];
  logic                 exp_halts [$];
  core_pkg::word_t      exp_pc;   // running pc while the table is built
  int                   errors;
  int                   cycles;

  localparam core_pkg::word_t nop = 32'h0000_0013; // addi x0, x0, 0

  rv_core_top i_dut (
    .clk       (clk),
    .arst_n    (arst_n),
    .inst      (inst),
    .mem_rdata (mem_rdata),
    .pc        (pc),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wmask (mem_wmask),
    .mem_we    (mem_we),
    .mem_re    (mem_re),
    .halt      (halt)
  );

  always #(clk_period / 2) clk = ~clk;

  function automatic core_pkg::word_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [2:0] f3, input logic [4:0] rd,
                                            input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic core_pkg::word_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_isa_pkg::opc_store};
  endfunction

  function automatic core_pkg::word_t enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                            input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic core_pkg::word_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_isa_pkg::opc_jal};
  endfunction

  // row with the pc taken from the running count
  task automatic add_row(input string name, input core_pkg::word_t i_word,
                         input core_pkg::word_t rdata, input logic we, input logic re,
                         input core_pkg::word_t addr, input core_pkg::byte_mask_t mask,
                         input core_pkg::word_t wdata, input logic hlt);
    names.push_back(name);
    insts.push_back(i_word);
    rdatas.push_back(rdata);
    exp_pcs.push_back(exp_pc);
    exp_wes.push_back(we);
    exp_res.push_back(re);
    exp_addrs.push_back(addr);
    exp_masks.push_back(mask);
    exp_wdatas.push_back(wdata);
    exp_halts.push_back(hlt);
    exp_pc = exp_pc + 32'd4;
  endtask

  task automatic check_value(input string name, input string field,
                             input core_pkg::word_t expected, input core_pkg::word_t actual);
    if (expected !== actual) begin
      $display("[ERROR] %s %s: expected %h, actual %h", name, field, expected, actual);
      errors++;
    end
  endtask

  `include "tb_program.svh"

  initial begin
    void'($urandom(32'h8f03));
    errors    = 0;
    clk       = 1'b0;
    arst_n    = 1'b0;
    inst      = nop;
    mem_rdata = '0;
    exp_pc    = 32'h8000_0000;
    build_program();

    repeat (5) @(posedge clk);
    #1;
    check_value("reset", "pc", 32'h8000_0000, pc);
    check_value("reset", "mem_we", 32'(1'b0), 32'(mem_we));
    check_value("reset", "mem_re", 32'(1'b0), 32'(mem_re));
    check_value("reset", "halt", 32'(1'b0), 32'(halt));
    arst_n = 1'b1;

    for (int i = 0; i < names.size(); i++) begin
      if (i > 0) begin
        @(posedge clk);
        #1;
      end
      inst      = insts[i];
      mem_rdata = rdatas[i];
      #(clk_period - 3ns); // sample shortly before the next edge
      check_value(names[i], "pc", exp_pcs[i], pc);
      check_value(names[i], "mem_we", 32'(exp_wes[i]), 32'(mem_we));
      check_value(names[i], "mem_re", 32'(exp_res[i]), 32'(mem_re));
      check_value(names[i], "mem_wmask", 32'(exp_masks[i]), 32'(mem_wmask));
      check_value(names[i], "mem_wdata", exp_wdatas[i], mem_wdata);
      check_value(names[i], "halt", 32'(exp_halts[i]), 32'(halt));
      if (exp_wes[i] || exp_res[i]) begin
        check_value(names[i], "mem_addr", exp_addrs[i], mem_addr);
      end
    end

    cycles = 0;
    while (!halt && cycles < halt_timeout) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!halt) begin
      $display("timed out: halt never went high after %0d cycles", cycles);
      errors++;
    end

    $display("run complete, %0d rows, %0d errors", names.size(), errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- rv_core.f
+incdir+testbench
verilog/core_pkg.sv
verilog/rv_isa_pkg.sv
verilog/pc_unit.sv
verilog/decoder.sv
verilog/register_file.sv
verilog/exec_unit.sv
verilog/lsu.sv
verilog/rv_core_top.sv
testbench/tb_rv_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f rv_core.f --top-module tb_rv_core -o sim_rv_core
./obj_dir/sim_rv_core > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
  exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
  exit 1
fi
